/* source/pcs_rx_pkg.sv */
package pcs_rx_pkg;

	// block and scrambler sizes
	localparam int LEN_CODED_BLOCK = 66;
	localparam int LEN_SCRAMBLER   = 58;
	localparam int LEN_SYNC_HEADER = 2;
	localparam int LEN_BLOCK_TYPE  = 8;
	localparam int LEN_COUNT       = 16;
	localparam int LEN_APB_ADDR    = 8;
	localparam int LEN_APB_DATA    = 32;

	// polynomial x^58 + x^39 + 1, numbered from the newest bit
	localparam int SCRAMBLER_TAP_A = 38;
	localparam int SCRAMBLER_TAP_B = 57;

	typedef logic [LEN_CODED_BLOCK-1:0] coded_block_t;
	typedef logic [LEN_SCRAMBLER-1:0]   scrambler_state_t;
	typedef logic [LEN_SYNC_HEADER-1:0] sync_header_t;
	typedef logic [LEN_COUNT-1:0]       count_t;
	typedef logic [LEN_APB_ADDR-1:0]    apb_addr_t;
	typedef logic [LEN_APB_DATA-1:0]    apb_data_t;

	// legal headers, 00 and 11 are invalid
	localparam sync_header_t SH_DATA = 2'b01;
	localparam sync_header_t SH_CTRL = 2'b10;

	// type field of an all-idle control block, bits 63..56
	localparam logic [LEN_BLOCK_TYPE-1:0] BLOCK_TYPE_IDLE = 8'h1E;

	// register map
	localparam apb_addr_t REG_CTRL     = 8'h00;
	localparam apb_addr_t REG_HDR_ERR  = 8'h04;
	localparam apb_addr_t REG_IDLE_CNT = 8'h08;
	localparam apb_addr_t REG_DATA_CNT = 8'h0C;
	localparam apb_addr_t REG_CLEAR    = 8'h10;

endpackage

/* source/sync_header_check.sv */
`timescale 1ns/1ps

module sync_header_check
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_enable,
	input  logic                     i_valid,
	input  logic                     i_tag,
	input  pcs_rx_pkg::coded_block_t i_data,
	input  logic                     i_clear,
	output logic                     o_valid,
	output logic                     o_tag,
	output pcs_rx_pkg::coded_block_t o_data,
	output logic                     o_header_error,
	output pcs_rx_pkg::count_t       o_error_count
);

	pcs_rx_pkg::sync_header_t sync_header;
	logic                     header_error;
	pcs_rx_pkg::coded_block_t data_q;
	logic                     valid_q;
	logic                     tag_q;
	logic                     header_error_q;
	pcs_rx_pkg::count_t       error_count;

	assign sync_header = i_data[pcs_rx_pkg::LEN_CODED_BLOCK-1 -: pcs_rx_pkg::LEN_SYNC_HEADER];

	// only valid blocks can be flagged
	assign header_error = i_valid && (sync_header != pcs_rx_pkg::SH_DATA) &&
		(sync_header != pcs_rx_pkg::SH_CTRL);

	// input register stage
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			valid_q        <= 1'b0;
			tag_q          <= 1'b0;
			header_error_q <= 1'b0;
			data_q         <= '0;
		end
		else if (i_enable)
		begin
			valid_q        <= i_valid;
			tag_q          <= i_tag;
			header_error_q <= header_error;
			data_q         <= i_data;
		end
	end

	// saturating count of illegal headers, clear wins over enable
	always_ff @(posedge i_clock)
	begin
		if (i_reset || i_clear)
			error_count <= '0;
		else if (i_enable && header_error && (error_count != '1))
			error_count <= error_count + 1'b1;
	end

	assign o_valid        = valid_q;
	assign o_tag          = tag_q;
	assign o_data         = data_q;
	assign o_header_error = header_error_q;
	assign o_error_count  = error_count;

endmodule

/* source/descrambler.sv */
`timescale 1ns/1ps

module descrambler
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_enable,
	input  logic                     i_valid,
	input  logic                     i_bypass,
	input  logic                     i_tag,
	input  logic                     i_header_error,
	input  pcs_rx_pkg::coded_block_t i_data,
	output logic                     o_valid,
	output logic                     o_tag,
	output logic                     o_header_error,
	output pcs_rx_pkg::coded_block_t o_data
);

	pcs_rx_pkg::scrambler_state_t state;
	pcs_rx_pkg::scrambler_state_t state_next;
	pcs_rx_pkg::coded_block_t     descrambled;
	pcs_rx_pkg::coded_block_t     data_q;
	logic                         valid_q;
	logic                         tag_q;
	logic                         header_error_q;

	// newest bit enters at the top, so tap n sits at index LEN-1-n
	always_comb
	begin
		state_next  = state;
		descrambled = i_data;
		for (int i = pcs_rx_pkg::LEN_CODED_BLOCK - pcs_rx_pkg::LEN_SYNC_HEADER - 1; i >= 0; i--)
		begin
			descrambled[i] = i_data[i] ^
				state_next[pcs_rx_pkg::LEN_SCRAMBLER-1-pcs_rx_pkg::SCRAMBLER_TAP_A] ^
				state_next[pcs_rx_pkg::LEN_SCRAMBLER-1-pcs_rx_pkg::SCRAMBLER_TAP_B];
			// self-synchronous, so the received bit feeds the state
			state_next = {i_data[i], state_next[pcs_rx_pkg::LEN_SCRAMBLER-1:1]};
		end
	end

	// state holds in bypass, advances on every enabled cycle otherwise
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			state <= '0;
		else if (i_enable && !i_bypass)
			state <= state_next;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			valid_q        <= 1'b0;
			header_error_q <= 1'b0;
			data_q         <= '0;
		end
		else if (i_enable)
		begin
			valid_q        <= i_valid;
			header_error_q <= i_header_error;
			data_q         <= i_bypass ? i_data : descrambled;
		end
	end

	// tag only follows real blocks
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			tag_q <= 1'b0;
		else if (i_enable && i_valid)
			tag_q <= i_tag;
	end

	assign o_valid        = valid_q;
	assign o_tag          = tag_q;
	assign o_header_error = header_error_q;
	assign o_data         = data_q;

endmodule

/* source/block_classifier.sv */
`timescale 1ns/1ps

module block_classifier
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_enable,
	input  logic                     i_valid,
	input  logic                     i_tag,
	input  logic                     i_header_error,
	input  pcs_rx_pkg::coded_block_t i_data,
	input  logic                     i_clear,
	output logic                     o_valid,
	output logic                     o_tag,
	output logic                     o_header_error,
	output pcs_rx_pkg::coded_block_t o_data,
	output pcs_rx_pkg::count_t       o_idle_count,
	output pcs_rx_pkg::count_t       o_data_count
);

	pcs_rx_pkg::sync_header_t            sync_header;
	logic [pcs_rx_pkg::LEN_BLOCK_TYPE-1:0] block_type;
	logic                                is_idle;
	logic                                is_data;
	pcs_rx_pkg::coded_block_t            data_q;
	logic                                valid_q;
	logic                                tag_q;
	logic                                header_error_q;
	pcs_rx_pkg::count_t                  idle_count;
	pcs_rx_pkg::count_t                  data_count;

	assign sync_header = i_data[pcs_rx_pkg::LEN_CODED_BLOCK-1 -: pcs_rx_pkg::LEN_SYNC_HEADER];
	// type field sits right below the header
	assign block_type = i_data[pcs_rx_pkg::LEN_CODED_BLOCK-pcs_rx_pkg::LEN_SYNC_HEADER-1 -:
		pcs_rx_pkg::LEN_BLOCK_TYPE];

	assign is_idle = i_valid && (sync_header == pcs_rx_pkg::SH_CTRL) &&
		(block_type == pcs_rx_pkg::BLOCK_TYPE_IDLE);
	assign is_data = i_valid && (sync_header == pcs_rx_pkg::SH_DATA);

	// output register stage
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			valid_q        <= 1'b0;
			tag_q          <= 1'b0;
			header_error_q <= 1'b0;
			data_q         <= '0;
		end
		else if (i_enable)
		begin
			valid_q        <= i_valid;
			tag_q          <= i_tag;
			header_error_q <= i_header_error;
			data_q         <= i_data;
		end
	end

	// saturating block counters
	always_ff @(posedge i_clock)
	begin
		if (i_reset || i_clear)
		begin
			idle_count <= '0;
			data_count <= '0;
		end
		else if (i_enable)
		begin
			if (is_idle && (idle_count != '1))
				idle_count <= idle_count + 1'b1;
			if (is_data && (data_count != '1))
				data_count <= data_count + 1'b1;
		end
	end

	assign o_valid        = valid_q;
	assign o_tag          = tag_q;
	assign o_header_error = header_error_q;
	assign o_data         = data_q;
	assign o_idle_count   = idle_count;
	assign o_data_count   = data_count;

endmodule

/* source/pcs_rx_apb_regs.sv */
`timescale 1ns/1ps

module pcs_rx_apb_regs
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_psel,
	input  logic                  i_penable,
	input  logic                  i_pwrite,
	input  pcs_rx_pkg::apb_addr_t i_paddr,
	input  pcs_rx_pkg::apb_data_t i_pwdata,
	input  pcs_rx_pkg::count_t    i_error_count,
	input  pcs_rx_pkg::count_t    i_idle_count,
	input  pcs_rx_pkg::count_t    i_data_count,
	output pcs_rx_pkg::apb_data_t o_prdata,
	output logic                  o_pslverr,
	output logic                  o_bypass,
	output logic                  o_clear
);

	logic                  access;
	logic                  write_access;
	logic                  mapped;
	logic                  bypass;
	pcs_rx_pkg::apb_data_t read_data;

	// zero wait states, the access phase is the only phase that acts
	assign access       = i_psel && i_penable;
	assign write_access = access && i_pwrite;

	always_comb
	begin
		mapped    = 1'b1;
		read_data = '0;
		case (i_paddr)
			pcs_rx_pkg::REG_CTRL:
				read_data = pcs_rx_pkg::apb_data_t'(bypass);
			pcs_rx_pkg::REG_HDR_ERR:
				read_data = pcs_rx_pkg::apb_data_t'(i_error_count);
			pcs_rx_pkg::REG_IDLE_CNT:
				read_data = pcs_rx_pkg::apb_data_t'(i_idle_count);
			pcs_rx_pkg::REG_DATA_CNT:
				read_data = pcs_rx_pkg::apb_data_t'(i_data_count);
			// write-only strobe, reads back zero
			pcs_rx_pkg::REG_CLEAR:
				read_data = '0;
			default:
				mapped = 1'b0;
		endcase
	end

	// bypass bit in REG_CTRL
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			bypass <= 1'b0;
		else if (write_access && (i_paddr == pcs_rx_pkg::REG_CTRL))
			bypass <= i_pwdata[0];
	end

	// counters see the pulse at the end of the access cycle
	assign o_clear = write_access && (i_paddr == pcs_rx_pkg::REG_CLEAR);

	assign o_pslverr = access && !mapped;
	assign o_prdata  = read_data;
	assign o_bypass  = bypass;

endmodule

/* source/pcs_rx_top.sv */
`timescale 1ns/1ps

module pcs_rx_top
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_enable,
	input  logic                     i_valid,
	input  logic                     i_tag,
	input  pcs_rx_pkg::coded_block_t i_data,
	input  logic                     i_psel,
	input  logic                     i_penable,
	input  logic                     i_pwrite,
	input  pcs_rx_pkg::apb_addr_t    i_paddr,
	input  pcs_rx_pkg::apb_data_t    i_pwdata,
	output logic                     o_valid,
	output logic                     o_tag,
	output logic                     o_header_error,
	output pcs_rx_pkg::coded_block_t o_data,
	output pcs_rx_pkg::apb_data_t    o_prdata,
	output logic                     o_pslverr
);

	// header check to descrambler
	logic                     sh_valid;
	logic                     sh_tag;
	logic                     sh_header_error;
	pcs_rx_pkg::coded_block_t sh_data;

	// descrambler to classifier
	logic                     ds_valid;
	logic                     ds_tag;
	logic                     ds_header_error;
	pcs_rx_pkg::coded_block_t ds_data;

	pcs_rx_pkg::count_t error_count;
	pcs_rx_pkg::count_t idle_count;
	pcs_rx_pkg::count_t data_count;
	logic               bypass;
	logic               clear;

	sync_header_check i_sync_header_check
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_enable       (i_enable),
		.i_valid        (i_valid),
		.i_tag          (i_tag),
		.i_data         (i_data),
		.i_clear        (clear),
		.o_valid        (sh_valid),
		.o_tag          (sh_tag),
		.o_data         (sh_data),
		.o_header_error (sh_header_error),
		.o_error_count  (error_count)
	);

	descrambler i_descrambler
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_enable       (i_enable),
		.i_valid        (sh_valid),
		.i_bypass       (bypass),
		.i_tag          (sh_tag),
		.i_header_error (sh_header_error),
		.i_data         (sh_data),
		.o_valid        (ds_valid),
		.o_tag          (ds_tag),
		.o_header_error (ds_header_error),
		.o_data         (ds_data)
	);

	block_classifier i_block_classifier
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_enable       (i_enable),
		.i_valid        (ds_valid),
		.i_tag          (ds_tag),
		.i_header_error (ds_header_error),
		.i_data         (ds_data),
		.i_clear        (clear),
		.o_valid        (o_valid),
		.o_tag          (o_tag),
		.o_header_error (o_header_error),
		.o_data         (o_data),
		.o_idle_count   (idle_count),
		.o_data_count   (data_count)
	);

	pcs_rx_apb_regs i_pcs_rx_apb_regs
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_psel        (i_psel),
		.i_penable     (i_penable),
		.i_pwrite      (i_pwrite),
		.i_paddr       (i_paddr),
		.i_pwdata      (i_pwdata),
		.i_error_count (error_count),
		.i_idle_count  (idle_count),
		.i_data_count  (data_count),
		.o_prdata      (o_prdata),
		.o_pslverr     (o_pslverr),
		.o_bypass      (bypass),
		.o_clear       (clear)
	);

endmodule

/* tb/tb_pcs_rx.sv */
`timescale 1ns/1ps

module tb_pcs_rx;

	localparam int HALF_PERIOD   = 4;
	localparam int RESET_CYCLES  = 10;
	localparam int NUM_BLOCKS    = 2000;
	localparam int NUM_BYPASS    = 300;
	localparam int DRAIN_CYCLES  = 4;
	localparam int APB_TRANSFERS = 26;
	// up to a gap, a stall and a block per step over the three runs
	localparam int STIM_CYCLES = 3 * (NUM_BLOCKS + 2 * NUM_BYPASS) + 3 * DRAIN_CYCLES +
		RESET_CYCLES;
	localparam int APB_CYCLES  = 3 * APB_TRANSFERS;
	localparam int CYCLE_LIMIT = 2 * (STIM_CYCLES + APB_CYCLES);

	localparam logic [31:0] LFSR_SEED = 32'hbfad;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	// x^58 + x^39 + 1 with hist[k] holding the bit sent k+1 bits ago
	localparam int POLY_NEAR    = 39;
	localparam int POLY_FAR     = 58;
	localparam int PAYLOAD_BITS = 64;
	// block sampled on enabled edge n is visible after edge n+2
	localparam int OUTPUT_GAP   = 2;

	logic                     i_clock;
	logic                     i_reset;
	logic                     i_enable;
	logic                     i_valid;
	logic                     i_tag;
	pcs_rx_pkg::coded_block_t i_data;
	logic                     i_psel;
	logic                     i_penable;
	logic                     i_pwrite;
	pcs_rx_pkg::apb_addr_t    i_paddr;
	pcs_rx_pkg::apb_data_t    i_pwdata;
	logic                     o_valid;
	logic                     o_tag;
	logic                     o_header_error;
	pcs_rx_pkg::coded_block_t o_data;
	pcs_rx_pkg::apb_data_t    o_prdata;
	logic                     o_pslverr;

	logic [31:0]                  lfsr;
	pcs_rx_pkg::scrambler_state_t tx_history;
	pcs_rx_pkg::coded_block_t     pending_line;
	logic                         bypass_model;
	int                           model_errors;
	int                           model_idles;
	int                           model_datas;
	int                           cycle_count;
	int                           enabled_cycles;
	logic                         enabled_edge;

	pcs_rx_pkg::coded_block_t exp_data_q[$];
	logic                     exp_tag_q[$];
	logic                     exp_err_q[$];
	int                       exp_idx_q[$];

	pcs_rx_top i_pcs_rx_top
	(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_enable       (i_enable),
		.i_valid        (i_valid),
		.i_tag          (i_tag),
		.i_data         (i_data),
		.i_psel         (i_psel),
		.i_penable      (i_penable),
		.i_pwrite       (i_pwrite),
		.i_paddr        (i_paddr),
		.i_pwdata       (i_pwdata),
		.o_valid        (o_valid),
		.o_tag          (o_tag),
		.o_header_error (o_header_error),
		.o_data         (o_data),
		.o_prdata       (o_prdata),
		.o_pslverr      (o_pslverr)
	);

	always #(HALF_PERIOD) i_clock = ~i_clock;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	function automatic logic [63:0] random_bits(input int count);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr  = lfsr_next(lfsr);
			value = {value[62:0], lfsr[0]};
		end
		return value;
	endfunction

	// mostly data, some idle and other control, a few illegal headers
	function automatic pcs_rx_pkg::coded_block_t random_block();
		logic [3:0]               kind;
		pcs_rx_pkg::sync_header_t header;
		logic [63:0]              payload;
		kind    = 4'(random_bits(4));
		payload = random_bits(PAYLOAD_BITS);
		if (kind == 4'd0)
			header = (random_bits(1) != 0) ? 2'b11 : 2'b00;
		else if (kind < 4'd4)
		begin
			header  = pcs_rx_pkg::SH_CTRL;
			payload = {pcs_rx_pkg::BLOCK_TYPE_IDLE, 56'h0};
		end
		else if (kind < 4'd6)
			header = pcs_rx_pkg::SH_CTRL;
		else
			header = pcs_rx_pkg::SH_DATA;
		return {header, payload};
	endfunction

	task check_value(input string name, input logic [65:0] actual, input logic [65:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// the previously sampled block enters the history on the edge that samples
	// this one, and only while not bypassed
	task drive_block(input logic enable, input logic valid, input logic tag,
		input pcs_rx_pkg::coded_block_t plain);
		pcs_rx_pkg::coded_block_t     line;
		pcs_rx_pkg::scrambler_state_t hist;
		pcs_rx_pkg::scrambler_state_t shift;
		pcs_rx_pkg::sync_header_t     header;
		hist   = tx_history;
		line   = plain;
		header = plain[65:64];
		if (!bypass_model)
		begin
			for (int i = PAYLOAD_BITS - 1; i >= 0; i--)
				hist = {hist[pcs_rx_pkg::LEN_SCRAMBLER-2:0], pending_line[i]};
			shift = hist;
			for (int i = PAYLOAD_BITS - 1; i >= 0; i--)
			begin
				line[i] = plain[i] ^ shift[POLY_NEAR-1] ^ shift[POLY_FAR-1];
				shift   = {shift[pcs_rx_pkg::LEN_SCRAMBLER-2:0], line[i]};
			end
		end
		@(negedge i_clock);
		i_enable = enable;
		i_valid  = valid;
		i_tag    = tag;
		i_data   = line;
		if (enable)
		begin
			tx_history   = hist;
			pending_line = line;
			if (valid)
			begin
				exp_data_q.push_back(plain);
				exp_tag_q.push_back(tag);
				exp_err_q.push_back(header == 2'b00 || header == 2'b11);
				exp_idx_q.push_back(enabled_cycles + 1);
				if (header == 2'b00 || header == 2'b11)
					model_errors++;
				if (header == pcs_rx_pkg::SH_CTRL &&
					plain[63:56] == pcs_rx_pkg::BLOCK_TYPE_IDLE)
					model_idles++;
				if (header == pcs_rx_pkg::SH_DATA)
					model_datas++;
			end
		end
	endtask

	task run_blocks(input int count);
		pcs_rx_pkg::coded_block_t block;
		logic                     tag;
		logic                     valid;
		for (int n = 0; n < count; n++)
		begin
			// idle gap with the enable high
			if (random_bits(2) == 0)
			begin
				block = random_block();
				tag   = random_bits(1) != 0;
				drive_block(1'b1, 1'b0, tag, block);
			end
			// enable drop where nothing is sampled
			if (random_bits(3) == 0)
			begin
				block = random_block();
				valid = random_bits(1) != 0;
				tag   = random_bits(1) != 0;
				drive_block(1'b0, valid, tag, block);
			end
			block = random_block();
			tag   = random_bits(1) != 0;
			drive_block(1'b1, 1'b1, tag, block);
		end
	endtask

	task drain_pipeline();
		pcs_rx_pkg::coded_block_t block;
		for (int n = 0; n < DRAIN_CYCLES; n++)
		begin
			block = random_block();
			drive_block(1'b1, 1'b0, 1'b0, block);
		end
		check_value("pending blocks", exp_data_q.size(), 0);
	endtask

	// setup then access phase where data is the write data or the expected read data
	task apb_transfer(input logic write, input pcs_rx_pkg::apb_addr_t addr,
		input pcs_rx_pkg::apb_data_t data, input logic expect_error);
		@(negedge i_clock);
		i_enable  = 1'b0;
		i_valid   = 1'b0;
		i_psel    = 1'b1;
		i_penable = 1'b0;
		i_pwrite  = write;
		i_paddr   = addr;
		i_pwdata  = write ? data : '0;
		@(negedge i_clock);
		i_penable = 1'b1;
		#(HALF_PERIOD / 2);
		check_value("o_pslverr", o_pslverr, expect_error);
		if (!write)
			check_value("o_prdata", o_prdata, data);
		@(negedge i_clock);
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
	endtask

	task check_counters();
		apb_transfer(1'b0, pcs_rx_pkg::REG_HDR_ERR, model_errors, 1'b0);
		apb_transfer(1'b0, pcs_rx_pkg::REG_IDLE_CNT, model_idles, 1'b0);
		apb_transfer(1'b0, pcs_rx_pkg::REG_DATA_CNT, model_datas, 1'b0);
	endtask

	always @(posedge i_clock)
	begin
		cycle_count++;
		enabled_edge = !i_reset && i_enable;
		if (enabled_edge)
			enabled_cycles++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	// outputs only move after an enabled edge
	always @(negedge i_clock)
	begin
		if (enabled_edge && o_valid)
		begin
			if (exp_data_q.size() == 0)
			begin
				$display("output block at time %0t with no block expected", $time);
				$display("*** FAILED ***");
				$fatal(1, "unexpected block");
			end
			else
			begin
				check_value("o_data", o_data, exp_data_q.pop_front());
				check_value("o_tag", o_tag, exp_tag_q.pop_front());
				check_value("o_header_error", o_header_error, exp_err_q.pop_front());
				check_value("latency", enabled_cycles - exp_idx_q.pop_front(), OUTPUT_GAP);
			end
		end
	end

	initial
	begin
		i_clock        = 1'b0;
		i_reset        = 1'b1;
		i_enable       = 1'b0;
		i_valid        = 1'b0;
		i_tag          = 1'b0;
		i_data         = '0;
		i_psel         = 1'b0;
		i_penable      = 1'b0;
		i_pwrite       = 1'b0;
		i_paddr        = '0;
		i_pwdata       = '0;
		lfsr           = LFSR_SEED;
		tx_history     = '0;
		pending_line   = '0;
		bypass_model   = 1'b0;
		model_errors   = 0;
		model_idles    = 0;
		model_datas    = 0;
		cycle_count    = 0;
		enabled_cycles = 0;
		enabled_edge   = 1'b0;

		repeat (RESET_CYCLES) @(negedge i_clock);
		i_reset = 1'b0;

		// reset values
		@(negedge i_clock);
		check_value("o_valid", o_valid, 1'b0);
		check_value("o_tag", o_tag, 1'b0);
		check_value("o_header_error", o_header_error, 1'b0);
		check_value("o_data", o_data, '0);
		check_value("o_pslverr", o_pslverr, 1'b0);
		apb_transfer(1'b0, pcs_rx_pkg::REG_CTRL, 32'h0, 1'b0);
		apb_transfer(1'b0, pcs_rx_pkg::REG_CLEAR, 32'h0, 1'b0);
		check_counters();

		// descrambling with random gaps and enable drops
		run_blocks(NUM_BLOCKS);
		drain_pipeline();
		check_counters();

		apb_transfer(1'b1, pcs_rx_pkg::REG_CLEAR, 32'h1, 1'b0);
		model_errors = 0;
		model_idles  = 0;
		model_datas  = 0;
		check_counters();

		// raw blocks while bypassed
		apb_transfer(1'b1, pcs_rx_pkg::REG_CTRL, 32'h1, 1'b0);
		bypass_model = 1'b1;
		apb_transfer(1'b0, pcs_rx_pkg::REG_CTRL, 32'h1, 1'b0);
		run_blocks(NUM_BYPASS);
		drain_pipeline();
		check_counters();

		// back to descrambling from the held state
		apb_transfer(1'b1, pcs_rx_pkg::REG_CTRL, 32'h0, 1'b0);
		bypass_model = 1'b0;
		apb_transfer(1'b0, pcs_rx_pkg::REG_CTRL, 32'h0, 1'b0);
		run_blocks(NUM_BYPASS);
		drain_pipeline();
		check_counters();

		// unmapped addresses
		apb_transfer(1'b1, 8'h20, 32'hffff_ffff, 1'b1);
		apb_transfer(1'b0, 8'h24, 32'h0, 1'b1);
		apb_transfer(1'b0, pcs_rx_pkg::REG_CTRL, 32'h0, 1'b0);

		if (exp_data_q.size() == 0)
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
		begin
			$display("%0d expected blocks never reached the output", exp_data_q.size());
			$display("*** FAILED ***");
			$fatal(1, "missing blocks");
		end
	end

endmodule

/* tb.f */
source/pcs_rx_pkg.sv
source/sync_header_check.sv
source/descrambler.sv
source/block_classifier.sv
source/pcs_rx_apb_regs.sv
source/pcs_rx_top.sv
tb/tb_pcs_rx.sv

/* Bender.yml */
package:
  name: pcs_rx

sources:
  - files:
      - source/pcs_rx_pkg.sv
      - source/sync_header_check.sv
      - source/descrambler.sv
      - source/block_classifier.sv
      - source/pcs_rx_apb_regs.sv
      - source/pcs_rx_top.sv
  - target: test
    files:
      - tb/tb_pcs_rx.sv
